/* Makefile */
TOP := tb_axi_master_agent

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build folder"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

/* hw/agent_pkg.sv */
`default_nettype none

package agent_pkg;

    // ------------------------------------------------------------------------
    // AXI3 channel widths
    // ------------------------------------------------------------------------
    localparam int ID_W   = 2;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int LEN_W  = 4;
    localparam int USER_W = 8;

    // Network packet field widths
    localparam int BYTE_CNT_W  = 8;
    localparam int BURSTWRAP_W = 8;
    localparam int SRC_ID_W    = 2;

    typedef enum logic [1:0]
    {
        burst_fixed    = 2'b00,
        burst_incr     = 2'b01,
        burst_wrap     = 2'b10,
        burst_reserved = 2'b11
    } burst_type_e;

    typedef enum logic
    {
        op_read  = 1'b0,
        op_write = 1'b1
    } pkt_op_e;

    // Shared by AW and AR
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [2:0]        size;
        burst_type_e       burst;
        logic              excl;
        logic [3:0]        cache;
        logic [2:0]        prot;
        logic [USER_W-1:0] user;
    } ax_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_beat_t;

    // ------------------------------------------------------------------------
    // Network packets
    // ------------------------------------------------------------------------
    typedef struct packed {
        pkt_op_e                op;
        logic [BYTE_CNT_W-1:0]  byte_cnt;
        logic                   excl;
        logic [BURSTWRAP_W-1:0] burstwrap;
        logic [ADDR_W-1:0]      addr;
        logic [DATA_W-1:0]      data;
        logic [STRB_W-1:0]      byteen;
        logic [2:0]             size;
        burst_type_e            burst;
        logic [SRC_ID_W-1:0]    src_id;
        logic [2:0]             prot;
        logic [ID_W-1:0]        thread_id;
        logic [3:0]             cache;
        logic [USER_W-1:0]      user;
    } cmd_pkt_t;

    typedef struct packed {
        logic [ID_W-1:0]   thread_id;
        logic [1:0]        resp;
        logic [DATA_W-1:0] data;
    } rsp_pkt_t;

endpackage

`default_nettype wire

/* hw/axi_master_agent.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_master_agent
#(
    parameter int unsigned SRC_ID = 1
)
(
    input  wire                                     aclk,
    input  wire                                     aresetn,
    // ------------------------------------------------------------------------
    // AXI side
    // ------------------------------------------------------------------------
    input  wire agent_pkg::ax_req_t                 aw,
    input  wire                                     awvalid,
    output logic                                    awready,
    input  wire agent_pkg::w_beat_t                 w,
    input  wire                                     wvalid,
    output logic                                    wready,
    output logic [agent_pkg::ID_W-1:0]              b_id,
    output logic [1:0]                              b_resp,
    output logic                                    bvalid,
    input  wire                                     bready,
    input  wire agent_pkg::ax_req_t                 ar,
    input  wire                                     arvalid,
    output logic                                    arready,
    output logic [agent_pkg::ID_W-1:0]              r_id,
    output logic [agent_pkg::DATA_W-1:0]            r_data,
    output logic [1:0]                              r_resp,
    output logic                                    rvalid,
    output logic                                    rlast,
    input  wire                                     rready,
    // ------------------------------------------------------------------------
    // Network side
    // ------------------------------------------------------------------------
    output agent_pkg::cmd_pkt_t                     wr_cmd,
    output logic                                    wr_cmd_valid,
    output logic                                    wr_cmd_sop,
    output logic                                    wr_cmd_eop,
    input  wire                                     wr_cmd_ready,
    input  wire agent_pkg::rsp_pkt_t                wr_rsp,
    input  wire                                     wr_rsp_valid,
    output logic                                    wr_rsp_ready,
    output agent_pkg::cmd_pkt_t                     rd_cmd,
    output logic                                    rd_cmd_valid,
    output logic                                    rd_cmd_sop,
    output logic                                    rd_cmd_eop,
    input  wire                                     rd_cmd_ready,
    input  wire agent_pkg::rsp_pkt_t                rd_rsp,
    input  wire                                     rd_rsp_valid,
    input  wire                                     rd_rsp_eop,
    output logic                                    rd_rsp_ready
);

    write_channel #(
        .SRC_ID (SRC_ID)
    ) u_write (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .aw           (aw),
        .awvalid      (awvalid),
        .awready      (awready),
        .w            (w),
        .wvalid       (wvalid),
        .wready       (wready),
        .wr_cmd       (wr_cmd),
        .wr_cmd_valid (wr_cmd_valid),
        .wr_cmd_sop   (wr_cmd_sop),
        .wr_cmd_eop   (wr_cmd_eop),
        .wr_cmd_ready (wr_cmd_ready),
        .wr_rsp       (wr_rsp),
        .wr_rsp_valid (wr_rsp_valid),
        .wr_rsp_ready (wr_rsp_ready),
        .b_id         (b_id),
        .b_resp       (b_resp),
        .bvalid       (bvalid),
        .bready       (bready)
    );

    // Read path is purely combinational
    read_channel #(
        .SRC_ID (SRC_ID)
    ) u_read (
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .rd_cmd       (rd_cmd),
        .rd_cmd_valid (rd_cmd_valid),
        .rd_cmd_sop   (rd_cmd_sop),
        .rd_cmd_eop   (rd_cmd_eop),
        .rd_cmd_ready (rd_cmd_ready),
        .rd_rsp       (rd_rsp),
        .rd_rsp_valid (rd_rsp_valid),
        .rd_rsp_eop   (rd_rsp_eop),
        .rd_rsp_ready (rd_rsp_ready),
        .r_id         (r_id),
        .r_data       (r_data),
        .r_resp       (r_resp),
        .rvalid       (rvalid),
        .rlast        (rlast),
        .rready       (rready)
    );

endmodule

`default_nettype wire

/* hw/burst_calc.sv */
`timescale 1ns/100ps
`default_nettype none

module burst_calc
(
    input  wire agent_pkg::ax_req_t                 req,
    output logic [7:0]                              beat_bytes,
    output logic [agent_pkg::BYTE_CNT_W-1:0]        total_bytes,
    output logic [agent_pkg::BURSTWRAP_W-1:0]       burstwrap,
    output logic [agent_pkg::ADDR_W-1:0]            aligned_addr
);

    import agent_pkg::*;

    localparam int STRB_SHIFT = $clog2(STRB_W);
    localparam int LOG_LEN_W  = $clog2(LEN_W + 1);

    logic [BYTE_CNT_W-1:0]  len_beats;
    logic [LOG_LEN_W-1:0]   len_log2;
    logic [4:0]             wrap_width;
    logic [BURSTWRAP_W-1:0] wrap_mask;

    // Ceiling log2 of the beat count, exact for legal wrap lengths
    function automatic logic [LOG_LEN_W-1:0] beats_log2(input logic [LEN_W-1:0] len);
        logic [LEN_W:0]       beats;
        logic [LOG_LEN_W-1:0] result;
        beats  = {1'b0, len} + 1'b1;
        result = '0;
        for (int i = 0; i < LEN_W; i++)
        begin
            if (beats > (1 << i))
                result = LOG_LEN_W'(i + 1);
        end
        return result;
    endfunction

    assign beat_bytes   = 8'd1 << req.size;
    assign len_beats    = BYTE_CNT_W'(req.len) + BYTE_CNT_W'(1);
    assign total_bytes  = len_beats << STRB_SHIFT;
    assign aligned_addr = req.addr & ~ADDR_W'(beat_bytes - 8'd1);

    // ------------------------------------------------------------------------
    // Wrap boundary mask
    // ------------------------------------------------------------------------
    assign len_log2   = beats_log2(req.len);
    assign wrap_width = 5'(req.size) + 5'(len_log2);

    always_comb
    begin
        for (int i = 0; i < BURSTWRAP_W; i++)
            wrap_mask[i] = (i < wrap_width);
    end

    always_comb
    begin
        case (req.burst)
            burst_incr:  burstwrap = {BURSTWRAP_W{1'b1}};
            burst_wrap:  burstwrap = wrap_mask;
            burst_fixed: burstwrap = BURSTWRAP_W'(beat_bytes - 8'd1);
            // Reserved type behaves as incr
            default:     burstwrap = {BURSTWRAP_W{1'b1}};
        endcase
    end

endmodule

`default_nettype wire

/* hw/read_channel.sv */
`timescale 1ns/100ps
`default_nettype none

module read_channel
#(
    parameter int unsigned SRC_ID = 1
)
(
    // AXI read address
    input  wire agent_pkg::ax_req_t                 ar,
    input  wire                                     arvalid,
    output logic                                    arready,
    // Network command stream
    output agent_pkg::cmd_pkt_t                     rd_cmd,
    output logic                                    rd_cmd_valid,
    output logic                                    rd_cmd_sop,
    output logic                                    rd_cmd_eop,
    input  wire                                     rd_cmd_ready,
    // Network response stream
    input  wire agent_pkg::rsp_pkt_t                rd_rsp,
    input  wire                                     rd_rsp_valid,
    input  wire                                     rd_rsp_eop,
    output logic                                    rd_rsp_ready,
    // AXI read data
    output logic [agent_pkg::ID_W-1:0]              r_id,
    output logic [agent_pkg::DATA_W-1:0]            r_data,
    output logic [1:0]                              r_resp,
    output logic                                    rvalid,
    output logic                                    rlast,
    input  wire                                     rready
);

    import agent_pkg::*;

    logic [BYTE_CNT_W-1:0]  total_bytes;
    logic [BURSTWRAP_W-1:0] burstwrap;

    // Read address is sent as given, so only the count and mask are needed
    burst_calc u_calc (
        .req          (ar),
        .beat_bytes   (),
        .total_bytes  (total_bytes),
        .burstwrap    (burstwrap),
        .aligned_addr ()
    );

    // ------------------------------------------------------------------------
    // Whole read request in a single packet
    // ------------------------------------------------------------------------
    assign rd_cmd_valid = arvalid;
    assign arready      = rd_cmd_ready;
    assign rd_cmd_sop   = 1'b1;
    assign rd_cmd_eop   = 1'b1;

    always_comb
    begin
        rd_cmd.op        = op_read;
        rd_cmd.byte_cnt  = total_bytes;
        rd_cmd.excl      = ar.excl;
        rd_cmd.burstwrap = burstwrap;
        rd_cmd.addr      = ar.addr;
        rd_cmd.data      = '0;
        rd_cmd.byteen    = {STRB_W{1'b1}};
        rd_cmd.size      = ar.size;
        rd_cmd.burst     = ar.burst;
        rd_cmd.src_id    = SRC_ID_W'(SRC_ID);
        rd_cmd.prot      = ar.prot;
        rd_cmd.thread_id = ar.id;
        rd_cmd.cache     = ar.cache;
        rd_cmd.user      = ar.user;
    end

    // One response packet per R beat
    assign rvalid       = rd_rsp_valid;
    assign rd_rsp_ready = rready;
    assign rlast        = rd_rsp_eop;
    assign r_id         = rd_rsp.thread_id;
    assign r_data       = rd_rsp.data;
    assign r_resp       = rd_rsp.resp;

endmodule

`default_nettype wire

/* hw/write_beat_tracker.sv */
`timescale 1ns/100ps
`default_nettype none

module write_beat_tracker
(
    input  wire                                     aclk,
    input  wire                                     aresetn,
    input  wire                                     beat_accept,
    input  wire                                     last,
    input  wire agent_pkg::burst_type_e             burst,
    input  wire [7:0]                               beat_bytes,
    input  wire [agent_pkg::BYTE_CNT_W-1:0]         total_bytes,
    input  wire [agent_pkg::BURSTWRAP_W-1:0]        burstwrap,
    input  wire [agent_pkg::ADDR_W-1:0]             aligned_addr,
    output logic                                    sop,
    output logic [agent_pkg::BYTE_CNT_W-1:0]        beat_byte_cnt,
    output logic [agent_pkg::ADDR_W-1:0]            beat_addr
);

    import agent_pkg::*;

    logic                  sop_q;
    logic [BYTE_CNT_W-1:0] byte_cnt_q;
    logic [ADDR_W-1:0]     addr_q;
    logic [ADDR_W-1:0]     incr_addr;
    logic [ADDR_W-1:0]     wrap_mask;
    logic [ADDR_W-1:0]     next_addr;

    // First beat takes the decoded burst values directly
    assign sop           = sop_q;
    assign beat_byte_cnt = sop_q ? total_bytes : byte_cnt_q;
    assign beat_addr     = sop_q ? aligned_addr : addr_q;

    // ------------------------------------------------------------------------
    // Next beat address
    // ------------------------------------------------------------------------
    assign incr_addr = beat_addr + ADDR_W'(beat_bytes);
    assign wrap_mask = ADDR_W'(burstwrap);

    always_comb
    begin
        case (burst)
            burst_fixed: next_addr = beat_addr;
            // Low bits wrap inside the boundary, upper bits hold
            burst_wrap:  next_addr = (beat_addr & ~wrap_mask) | (incr_addr & wrap_mask);
            default:     next_addr = incr_addr;
        endcase
    end

    // Start of packet returns after the last beat
    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            sop_q <= 1'b1;
        end
        else if (beat_accept)
        begin
            sop_q <= last;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (beat_accept)
        begin
            byte_cnt_q <= beat_byte_cnt - BYTE_CNT_W'(STRB_W);
            addr_q     <= next_addr;
        end
    end

endmodule

`default_nettype wire

/* hw/write_channel.sv */
`timescale 1ns/100ps
`default_nettype none

module write_channel
#(
    parameter int unsigned SRC_ID = 1
)
(
    input  wire                                     aclk,
    input  wire                                     aresetn,
    // AXI write address and data
    input  wire agent_pkg::ax_req_t                 aw,
    input  wire                                     awvalid,
    output logic                                    awready,
    input  wire agent_pkg::w_beat_t                 w,
    input  wire                                     wvalid,
    output logic                                    wready,
    // Network command stream
    output agent_pkg::cmd_pkt_t                     wr_cmd,
    output logic                                    wr_cmd_valid,
    output logic                                    wr_cmd_sop,
    output logic                                    wr_cmd_eop,
    input  wire                                     wr_cmd_ready,
    // Network response stream
    input  wire agent_pkg::rsp_pkt_t                wr_rsp,
    input  wire                                     wr_rsp_valid,
    output logic                                    wr_rsp_ready,
    // AXI write response
    output logic [agent_pkg::ID_W-1:0]              b_id,
    output logic [1:0]                              b_resp,
    output logic                                    bvalid,
    input  wire                                     bready
);

    import agent_pkg::*;

    logic [7:0]             beat_bytes;
    logic [BYTE_CNT_W-1:0]  total_bytes;
    logic [BURSTWRAP_W-1:0] burstwrap;
    logic [ADDR_W-1:0]      aligned_addr;
    logic                   both_valid;
    logic                   beat_accept;
    logic                   sop;
    logic [BYTE_CNT_W-1:0]  beat_byte_cnt;
    logic [ADDR_W-1:0]      beat_addr;

    burst_calc u_calc (
        .req          (aw),
        .beat_bytes   (beat_bytes),
        .total_bytes  (total_bytes),
        .burstwrap    (burstwrap),
        .aligned_addr (aligned_addr)
    );

    write_beat_tracker u_tracker (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .beat_accept   (beat_accept),
        .last          (w.last),
        .burst         (aw.burst),
        .beat_bytes    (beat_bytes),
        .total_bytes   (total_bytes),
        .burstwrap     (burstwrap),
        .aligned_addr  (aligned_addr),
        .sop           (sop),
        .beat_byte_cnt (beat_byte_cnt),
        .beat_addr     (beat_addr)
    );

    // ------------------------------------------------------------------------
    // One packet per beat, address held until the last beat goes out
    // ------------------------------------------------------------------------
    assign both_valid   = awvalid && wvalid;
    assign beat_accept  = both_valid && wr_cmd_ready;
    assign wr_cmd_valid = both_valid;
    assign wready       = beat_accept;
    assign awready      = beat_accept && w.last;
    assign wr_cmd_sop   = sop;
    assign wr_cmd_eop   = w.last;

    always_comb
    begin
        wr_cmd.op        = op_write;
        wr_cmd.byte_cnt  = beat_byte_cnt;
        wr_cmd.excl      = aw.excl;
        wr_cmd.burstwrap = burstwrap;
        wr_cmd.addr      = beat_addr;
        wr_cmd.data      = w.data;
        wr_cmd.byteen    = w.strb;
        wr_cmd.size      = aw.size;
        wr_cmd.burst     = aw.burst;
        wr_cmd.src_id    = SRC_ID_W'(SRC_ID);
        wr_cmd.prot      = aw.prot;
        wr_cmd.thread_id = aw.id;
        wr_cmd.cache     = aw.cache;
        wr_cmd.user      = aw.user;
    end

    // Write response onto B
    assign bvalid       = wr_rsp_valid;
    assign wr_rsp_ready = bready;
    assign b_id         = wr_rsp.thread_id;
    assign b_resp       = wr_rsp.resp;

endmodule

`default_nettype wire

/* src.f */
hw/agent_pkg.sv
hw/burst_calc.sv
hw/write_beat_tracker.sv
hw/write_channel.sv
hw/read_channel.sv
hw/axi_master_agent.sv
tb/tb_clock_gen.sv
tb/tb_axi_master_agent.sv

/* tb/tb_axi_master_agent.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_axi_master_agent;

    import agent_pkg::*;

    localparam int SRC_ID = 1;
    // All tests together need under 300 cycles
    localparam int TEST_CYCLES = 300;
    localparam int MAX_CYCLES  = TEST_CYCLES * 6 + 200;

    logic                  aclk;
    logic                  aresetn;
    ax_req_t               aw;
    ax_req_t               ar;
    w_beat_t               w;
    rsp_pkt_t              wr_rsp;
    rsp_pkt_t              rd_rsp;
    logic                  awvalid;
    logic                  wvalid;
    logic                  arvalid;
    logic                  bready;
    logic                  rready;
    logic                  wr_cmd_ready;
    logic                  rd_cmd_ready;
    logic                  wr_rsp_valid;
    logic                  rd_rsp_valid;
    logic                  rd_rsp_eop;
    logic                  awready;
    logic                  wready;
    logic                  arready;
    logic [ID_W-1:0]       b_id;
    logic [1:0]            b_resp;
    logic                  bvalid;
    logic [ID_W-1:0]       r_id;
    logic [DATA_W-1:0]     r_data;
    logic [1:0]            r_resp;
    logic                  rvalid;
    logic                  rlast;
    cmd_pkt_t              wr_cmd;
    logic                  wr_cmd_valid;
    logic                  wr_cmd_sop;
    logic                  wr_cmd_eop;
    logic                  wr_rsp_ready;
    cmd_pkt_t              rd_cmd;
    logic                  rd_cmd_valid;
    logic                  rd_cmd_sop;
    logic                  rd_cmd_eop;
    logic                  rd_rsp_ready;

    int                    errors = 0;
    int                    checks = 0;
    int                    tests_run = 0;
    int                    errors_before = 0;
    int                    cycles = 0;
    string                 current_test = "";
    logic [31:0]           lfsr_state;
    // Expected per-beat addresses of the burst under test
    logic [ADDR_W-1:0]     exp_addr [0:15];

    tb_clock_gen #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (5)
    ) u_clock (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    axi_master_agent #(
        .SRC_ID (SRC_ID)
    ) dut0 (
        .aclk (aclk), .aresetn (aresetn),
        .aw (aw), .awvalid (awvalid), .awready (awready),
        .w (w), .wvalid (wvalid), .wready (wready),
        .b_id (b_id), .b_resp (b_resp), .bvalid (bvalid), .bready (bready),
        .ar (ar), .arvalid (arvalid), .arready (arready),
        .r_id (r_id), .r_data (r_data), .r_resp (r_resp),
        .rvalid (rvalid), .rlast (rlast), .rready (rready),
        .wr_cmd (wr_cmd), .wr_cmd_valid (wr_cmd_valid), .wr_cmd_sop (wr_cmd_sop),
        .wr_cmd_eop (wr_cmd_eop), .wr_cmd_ready (wr_cmd_ready),
        .wr_rsp (wr_rsp), .wr_rsp_valid (wr_rsp_valid), .wr_rsp_ready (wr_rsp_ready),
        .rd_cmd (rd_cmd), .rd_cmd_valid (rd_cmd_valid), .rd_cmd_sop (rd_cmd_sop),
        .rd_cmd_eop (rd_cmd_eop), .rd_cmd_ready (rd_cmd_ready),
        .rd_rsp (rd_rsp), .rd_rsp_valid (rd_rsp_valid), .rd_rsp_eop (rd_rsp_eop),
        .rd_rsp_ready (rd_rsp_ready)
    );

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic check_value(input string field, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAILED %s %s: expected 0x%0h, actual 0x%0h",
                     current_test, field, expected, actual);
        end
    endtask

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        else
            return s >> 1;
    endfunction

    task automatic next_random_bit(output logic b);
        lfsr_state = lfsr_next(lfsr_state);
        b = lfsr_state[0];
    endtask

    function automatic ax_req_t make_req(input logic [ID_W-1:0] id, input logic [31:0] addr,
                                         input logic [3:0] len, input burst_type_e burst);
        ax_req_t r;
        r.id    = id;
        r.addr  = addr;
        r.len   = len;
        r.size  = 3'd2;
        r.burst = burst;
        r.excl  = id[0];
        r.cache = 4'hB;
        r.prot  = 3'h5;
        r.user  = {6'h2A, id};
        return r;
    endfunction

    task automatic start_test(input string name);
        current_test  = name;
        errors_before = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_before)
            $display("%s: passed", current_test);
        else
            $display("%s: failed with %0d mismatches", current_test, errors - errors_before);
    endtask

    task automatic init_inputs();
        aw           <= '0;
        ar           <= '0;
        w            <= '0;
        wr_rsp       <= '0;
        rd_rsp       <= '0;
        awvalid      <= 1'b0;
        wvalid       <= 1'b0;
        arvalid      <= 1'b0;
        bready       <= 1'b0;
        rready       <= 1'b0;
        wr_cmd_ready <= 1'b0;
        rd_cmd_ready <= 1'b0;
        wr_rsp_valid <= 1'b0;
        rd_rsp_valid <= 1'b0;
        rd_rsp_eop   <= 1'b0;
    endtask

    // Copied request fields, common to both command packets
    task automatic check_copied(input cmd_pkt_t pkt, input ax_req_t req);
        check_value("thread_id", req.id, pkt.thread_id);
        check_value("excl", req.excl, pkt.excl);
        check_value("size", req.size, pkt.size);
        check_value("burst", req.burst, pkt.burst);
        check_value("prot", req.prot, pkt.prot);
        check_value("cache", req.cache, pkt.cache);
        check_value("user", req.user, pkt.user);
        check_value("src_id", SRC_ID, pkt.src_id);
    endtask

    // ------------------------------------------------------------------------
    // Write burst, one packet per accepted beat
    // ------------------------------------------------------------------------
    task automatic drive_write_burst(input ax_req_t req, input logic [7:0] exp_wrap,
                                     input logic random_ready);
        int          beats;
        int          beat;
        logic        rdy;
        logic        last_v;
        logic [31:0] data_v;
        logic [3:0]  strb_v;
        beats = int'(req.len) + 1;
        beat  = 0;
        @(posedge aclk);
        aw      <= req;
        awvalid <= 1'b1;
        while (beat < beats)
        begin
            if (random_ready)
                next_random_bit(rdy);
            else
                rdy = 1'b1;
            last_v = (beat == beats - 1);
            data_v = 32'hD000_0000 + beat;
            strb_v = 4'(beat + 1);
            w            <= '{data: data_v, strb: strb_v, last: last_v};
            wvalid       <= 1'b1;
            wr_cmd_ready <= rdy;
            @(negedge aclk);
            check_value("wr_cmd_valid", 1'b1, wr_cmd_valid);
            check_value("wready", rdy, wready);
            check_value("awready", rdy && last_v, awready);
            check_value("sop", beat == 0, wr_cmd_sop);
            check_value("eop", last_v, wr_cmd_eop);
            check_value("op", op_write, wr_cmd.op);
            check_value("addr", exp_addr[beat], wr_cmd.addr);
            check_value("byte_cnt", (beats - beat) * STRB_W, wr_cmd.byte_cnt);
            check_value("burstwrap", exp_wrap, wr_cmd.burstwrap);
            check_value("data", data_v, wr_cmd.data);
            check_value("byteen", strb_v, wr_cmd.byteen);
            check_copied(wr_cmd, req);
            if (rdy)
                beat++;
            @(posedge aclk);
        end
        awvalid      <= 1'b0;
        wvalid       <= 1'b0;
        wr_cmd_ready <= 1'b0;
    endtask

    task automatic drive_read(input ax_req_t req, input logic [7:0] exp_wrap);
        logic rdy;
        logic done;
        done = 1'b0;
        @(posedge aclk);
        ar      <= req;
        arvalid <= 1'b1;
        while (!done)
        begin
            next_random_bit(rdy);
            rd_cmd_ready <= rdy;
            @(negedge aclk);
            check_value("rd_cmd_valid", 1'b1, rd_cmd_valid);
            check_value("arready", rdy, arready);
            check_value("sop", 1'b1, rd_cmd_sop);
            check_value("eop", 1'b1, rd_cmd_eop);
            check_value("op", op_read, rd_cmd.op);
            check_value("addr", req.addr, rd_cmd.addr);
            check_value("byte_cnt", (int'(req.len) + 1) * STRB_W, rd_cmd.byte_cnt);
            check_value("burstwrap", exp_wrap, rd_cmd.burstwrap);
            check_value("byteen", 4'hF, rd_cmd.byteen);
            check_value("data", 32'h0, rd_cmd.data);
            check_copied(rd_cmd, req);
            done = rdy;
            @(posedge aclk);
        end
        arvalid      <= 1'b0;
        rd_cmd_ready <= 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic test_reset_idle();
        start_test("reset_idle");
        @(negedge aclk);
        check_value("awready", 1'b0, awready);
        check_value("wready", 1'b0, wready);
        check_value("wr_cmd_valid", 1'b0, wr_cmd_valid);
        check_value("wr_rsp_ready", 1'b0, wr_rsp_ready);
        check_value("bvalid", 1'b0, bvalid);
        check_value("arready", 1'b0, arready);
        check_value("rd_cmd_valid", 1'b0, rd_cmd_valid);
        check_value("rd_rsp_ready", 1'b0, rd_rsp_ready);
        check_value("rvalid", 1'b0, rvalid);
        end_test();
    endtask

    task automatic test_single_beat_write();
        start_test("single_beat_write");
        exp_addr[0] = 32'h1004;
        drive_write_burst(make_req(2'd1, 32'h1006, 4'd0, burst_incr), 8'hFF, 1'b0);
        end_test();
    endtask

    task automatic test_incr_burst_write();
        start_test("incr_burst_write");
        for (int i = 0; i < 4; i++)
            exp_addr[i] = 32'h200 + 32'(i * 4);
        drive_write_burst(make_req(2'd2, 32'h200, 4'd3, burst_incr), 8'hFF, 1'b1);
        end_test();
    endtask

    task automatic test_wrap_burst_write();
        start_test("wrap_burst_write");
        exp_addr[0] = 32'h38;
        exp_addr[1] = 32'h3C;
        exp_addr[2] = 32'h30;
        exp_addr[3] = 32'h34;
        drive_write_burst(make_req(2'd3, 32'h38, 4'd3, burst_wrap), 8'h0F, 1'b0);
        end_test();
    endtask

    task automatic test_reads();
        start_test("reads");
        // Fixed burst mask is bytes per beat minus one
        drive_read(make_req(2'd1, 32'h3002, 4'd0, burst_fixed), 8'h03);
        drive_read(make_req(2'd2, 32'h4000, 4'd7, burst_incr), 8'hFF);
        end_test();
    endtask

    task automatic test_responses();
        logic     rdy;
        rsp_pkt_t pkt;
        start_test("responses");
        @(posedge aclk);
        wr_rsp       <= '{thread_id: 2'd2, resp: 2'b01, data: 32'h0};
        wr_rsp_valid <= 1'b1;
        @(negedge aclk);
        check_value("bvalid", 1'b1, bvalid);
        check_value("b_id", 2'd2, b_id);
        check_value("b_resp", 2'b01, b_resp);
        check_value("wr_rsp_ready", 1'b0, wr_rsp_ready);
        @(posedge aclk);
        bready <= 1'b1;
        @(negedge aclk);
        check_value("wr_rsp_ready", 1'b1, wr_rsp_ready);
        @(posedge aclk);
        wr_rsp_valid <= 1'b0;
        bready       <= 1'b0;
        @(negedge aclk);
        check_value("bvalid", 1'b0, bvalid);

        // Three read beats, last one flagged
        for (int i = 0; i < 3; i++)
        begin
            @(posedge aclk);
            next_random_bit(rdy);
            pkt.thread_id = 2'd3;
            pkt.resp      = (i == 2) ? 2'b10 : 2'b00;
            pkt.data      = 32'h1234_5600 + 32'(i);
            rd_rsp       <= pkt;
            rd_rsp_valid <= 1'b1;
            rd_rsp_eop   <= (i == 2);
            rready       <= rdy;
            @(negedge aclk);
            check_value("rvalid", 1'b1, rvalid);
            check_value("rd_rsp_ready", rdy, rd_rsp_ready);
            check_value("r_id", pkt.thread_id, r_id);
            check_value("r_data", pkt.data, r_data);
            check_value("r_resp", pkt.resp, r_resp);
            check_value("rlast", i == 2, rlast);
        end
        @(posedge aclk);
        rd_rsp_valid <= 1'b0;
        rd_rsp_eop   <= 1'b0;
        rready       <= 1'b0;
        @(negedge aclk);
        check_value("rvalid", 1'b0, rvalid);
        end_test();
    endtask

    // Run limit
    always @(posedge aclk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    initial
    begin
        init_inputs();
        lfsr_state = 32'd99556;
        // The reset starts high for a moment, so wait for its assertion first
        @(negedge aresetn);
        @(posedge aresetn);
        test_reset_idle();
        test_single_beat_write();
        test_incr_burst_write();
        test_wrap_burst_write();
        test_reads();
        test_responses();
        $display("Tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
#(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 5
)
(
    output logic aclk,
    output logic aresetn
);

    initial
    begin
        aclk = 1'b0;
        forever
            #(PERIOD_NS / 2) aclk = ~aclk;
    end

    // Brief high at start so the reset has a real falling edge
    initial
    begin
        aresetn <= 1'b1;
        #1 aresetn <= 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        aresetn <= 1'b1;
    end

endmodule

`default_nettype wire
